//--- fetch_frontend.f
+incdir+include
hdl/fetch_pkg.sv
hdl/buffer_pkg.sv
hdl/buffer_reg.sv
hdl/buffer_ctrl.sv
hdl/buffer.sv
hdl/fetch_unit.sv
hdl/fetch_frontend.sv
verif/fetch_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = fetch_tb
FILELIST  = fetch_frontend.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/fetch_tb.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_tb;

  import fetch_pkg::*;

  localparam int CLK_PERIOD    = 4;
  localparam int RESET_CYCLES  = 4;
  localparam int IDLE_CYCLES   = 6;
  localparam int STREAM_CYCLES = 40;
  localparam int OFFSET_CYCLES = 20;
  localparam int STALL_LEAD    = 10;
  localparam int STALL_CYCLES  = 30;
  localparam int RANDOM_ROUNDS = 8;
  localparam int ROUND_CYCLES  = 16;
  localparam int ISSUE_LIMIT   = 8;
  localparam int FILL_LIMIT    = 12;
  localparam int REF_DEPTH     = 160;
  localparam int REDIRECTS     = 5 + RANDOM_ROUNDS;
  localparam int RUN_CYCLES    = RESET_CYCLES + IDLE_CYCLES + 2 * STREAM_CYCLES
    + 3 * OFFSET_CYCLES + STALL_LEAD + STALL_CYCLES + RANDOM_ROUNDS * ROUND_CYCLES
    + REDIRECTS * (ISSUE_LIMIT + 2);
  localparam int WATCHDOG_NS   = (RUN_CYCLES + 200) * CLK_PERIOD;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
  } expect_t;

  logic        clock;
  logic        reset = 1'b0;
  logic        redirect = 1'b0;
  logic [31:0] redirect_pc = '0;
  logic        backend_stall = 1'b0;
  fetch_rsp_t  mem_rsp = '0;
  fetch_req_t  mem_req;
  issue_t      issue;

  logic [15:0] prog [256];
  expect_t     ref_q [$];
  expect_t     head0 = '0;
  expect_t     head1 = '0;
  logic        have0 = 1'b0;
  logic        have1 = 1'b0;
  logic        started = 1'b0;
  int          stall_run = 0;
  int          value_errs = 0;
  int          other_errs = 0;
  integer      seed = 32'h5f7d;
  logic [31:0] rnd;

  fetch_frontend DUT (
    .clock         (clock),
    .reset         (reset),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc),
    .backend_stall (backend_stall),
    .mem_rsp       (mem_rsp),
    .mem_req       (mem_req),
    .issue         (issue)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  function automatic logic [15:0] halfword_at(input logic [31:0] addr);
    return prog[addr[8:1]];
  endfunction

  function automatic logic [63:0] packet_at(input logic [31:0] addr);
    logic [31:0] base;
    base = {addr[31:3], 3'b000};
    return {halfword_at(base + 32'd6), halfword_at(base + 32'd4),
            halfword_at(base + 32'd2), halfword_at(base)};
  endfunction

  // Both low bits set marks a 32-bit instruction.
  function automatic logic is_full_length(input logic [15:0] hw);
    return hw[1:0] == 2'b11;
  endfunction

  task automatic fill_program();
    for (int i = 0; i < 256; i++) begin
      rnd = $random(seed);
      prog[i] = rnd[15:0];
      prog[i][1:0] = rnd[16] ? 2'b11 : {1'b0, rnd[17]};
    end
    // 32-bit instruction at the last halfword of a packet.
    prog[8'hc3][1:0] = 2'b11;
  endtask

  task automatic rebuild_reference(input logic [31:0] target);
    logic [31:0] pc;
    logic [15:0] hw;
    expect_t     item;
    pc = target;
    ref_q.delete();
    for (int n = 0; n < REF_DEPTH; n++) begin
      hw = halfword_at(pc);
      item.pc = pc;
      if (is_full_length(hw)) begin
        item.instr = {halfword_at(pc + 32'd2), hw};
        pc = pc + 32'd4;
      end else begin
        item.instr = {16'h0000, hw};
        pc = pc + 32'd2;
      end
      ref_q.push_back(item);
    end
  endtask

  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
    value_errs++;
  endtask

  task automatic protocol_error(input string msg);
    $display("%s at %0t", msg, $time);
    other_errs++;
  endtask

  // Memory answers one cycle after each request.
  always @(posedge clock) begin
    mem_rsp.ready <= mem_req.valid;
    mem_rsp.rdata <= packet_at(mem_req.addr);
  end

  // Reference queue follows redirects and consumed slots.
  always @(posedge clock) begin
    if (!reset) begin
      stall_run <= 0;
    end else begin
      if (redirect) begin
        started <= 1'b1;
        rebuild_reference(redirect_pc);
      end else begin
        if (issue.ready0 && ref_q.size() > 0) void'(ref_q.pop_front());
        if (issue.ready1 && ref_q.size() > 0) void'(ref_q.pop_front());
      end
      stall_run <= (backend_stall && !redirect) ? stall_run + 1 : 0;
    end
    have0 <= ref_q.size() > 0;
    have1 <= ref_q.size() > 1;
    head0 <= (ref_q.size() > 0) ? ref_q[0] : '0;
    head1 <= (ref_q.size() > 1) ? ref_q[1] : '0;
  end

  assert property (@(posedge clock) disable iff (!reset)
    !started && !redirect |-> !mem_req.valid && !issue.ready0 && !issue.ready1)
  else protocol_error("fetch or issue activity before the first redirect");

  assert property (@(posedge clock) disable iff (!reset)
    issue.ready0 && have0 |-> issue.pc0 == head0.pc)
  else value_error("pc0", $sampled(issue.pc0), $sampled(head0.pc));

  assert property (@(posedge clock) disable iff (!reset)
    issue.ready0 && have0 |-> issue.instr0 == head0.instr)
  else value_error("instr0", $sampled(issue.instr0), $sampled(head0.instr));

  assert property (@(posedge clock) disable iff (!reset)
    issue.ready1 && have1 |-> issue.pc1 == head1.pc)
  else value_error("pc1", $sampled(issue.pc1), $sampled(head1.pc));

  assert property (@(posedge clock) disable iff (!reset)
    issue.ready1 && have1 |-> issue.instr1 == head1.instr)
  else value_error("instr1", $sampled(issue.instr1), $sampled(head1.instr));

  assert property (@(posedge clock) disable iff (!reset) issue.ready0 |-> have0)
  else protocol_error("first slot issued past the end of the reference stream");

  assert property (@(posedge clock) disable iff (!reset) issue.ready1 |-> have1)
  else protocol_error("second slot issued past the end of the reference stream");

  // Idle slots, before reset release too.
  assert property (@(posedge clock) !issue.ready0 |-> issue.pc0 == '1)
  else value_error("pc0", $sampled(issue.pc0), 32'hffff_ffff);

  assert property (@(posedge clock) !issue.ready0 |-> issue.instr0 == '0)
  else value_error("instr0", $sampled(issue.instr0), 32'h0);

  assert property (@(posedge clock) !issue.ready1 |-> issue.pc1 == '1)
  else value_error("pc1", $sampled(issue.pc1), 32'hffff_ffff);

  assert property (@(posedge clock) !issue.ready1 |-> issue.instr1 == '0)
  else value_error("instr1", $sampled(issue.instr1), 32'h0);

  assert property (@(posedge clock) disable iff (!reset)
    backend_stall |-> !issue.ready0 && !issue.ready1)
  else protocol_error("instruction issued while the back end stalls");

  assert property (@(posedge clock) disable iff (!reset)
    stall_run > FILL_LIMIT && !redirect |-> !mem_req.valid)
  else protocol_error("fetch still requesting after the buffer should be full");

  assert property (@(posedge clock) mem_req.addr[2:0] == 3'b000)
  else value_error("mem_req.addr", $sampled(mem_req.addr), {$sampled(mem_req.addr[31:3]), 3'b0});

  task automatic run_cycles(input int n);
    repeat (n) @(posedge clock);
  endtask

  task automatic redirect_to(input logic [31:0] pc);
    redirect    <= 1'b1;
    redirect_pc <= pc;
    @(posedge clock);
    redirect    <= 1'b0;
  endtask

  task automatic wait_first_issue();
    int n;
    n = 0;
    do begin
      @(negedge clock);
      n++;
    end while (!issue.ready0 && n < ISSUE_LIMIT);
    if (!issue.ready0) begin
      protocol_error("no instruction issued after a redirect");
    end
    @(posedge clock);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    fill_program();
    run_cycles(RESET_CYCLES);
    reset <= 1'b1;
    run_cycles(IDLE_CYCLES);

    redirect_to(32'h0000_0040);
    wait_first_issue();
    run_cycles(STREAM_CYCLES);

    // Halfword offsets 1, 2 and 3, each mid-stream.
    redirect_to(32'h0000_0082);
    wait_first_issue();
    run_cycles(OFFSET_CYCLES);
    redirect_to(32'h0000_0104);
    wait_first_issue();
    run_cycles(OFFSET_CYCLES);
    redirect_to(32'h0000_0186);
    wait_first_issue();
    run_cycles(OFFSET_CYCLES);

    redirect_to(32'h0000_0200);
    wait_first_issue();
    run_cycles(STALL_LEAD);
    backend_stall <= 1'b1;
    run_cycles(STALL_CYCLES);
    backend_stall <= 1'b0;
    run_cycles(STREAM_CYCLES);

    repeat (RANDOM_ROUNDS) begin
      rnd = $random(seed);
      redirect_to(rnd & 32'h0000_3ffe);
      repeat (ROUND_CYCLES) begin
        rnd = $random(seed);
        backend_stall <= (rnd[2:0] == 3'd0);
        @(posedge clock);
      end
      backend_stall <= 1'b0;
    end

    run_cycles(2);
    $display("errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/fetch_frontend.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_frontend (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  redirect,
  input  logic [31:0]           redirect_pc,
  input  logic                  backend_stall,
  input  fetch_pkg::fetch_rsp_t mem_rsp,
  output fetch_pkg::fetch_req_t mem_req,
  output fetch_pkg::issue_t     issue
);

  import fetch_pkg::*;

  buffer_in_t  buffer_in;
  buffer_out_t buffer_out;

  fetch_unit u_fetch_unit (
    .clock            (clock),
    .reset            (reset),
    .redirect         (redirect),
    .redirect_pc      (redirect_pc),
    .backend_stall    (backend_stall),
    .mem_rsp          (mem_rsp),
    .mem_req          (mem_req),
    .buffer_out_stall (buffer_out.stall),
    .buffer_in        (buffer_in)
  );

  buffer u_buffer (
    .clock      (clock),
    .reset      (reset),
    .buffer_in  (buffer_in),
    .buffer_out (buffer_out)
  );

  // Stall stays inside the front end.
  assign issue.pc0    = buffer_out.pc0;
  assign issue.pc1    = buffer_out.pc1;
  assign issue.instr0 = buffer_out.instr0;
  assign issue.instr1 = buffer_out.instr1;
  assign issue.ready0 = buffer_out.ready0;
  assign issue.ready1 = buffer_out.ready1;

endmodule

`default_nettype wire

//--- hdl/fetch_unit.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_unit (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  redirect,
  input  logic [31:0]           redirect_pc,
  input  logic                  backend_stall,
  input  fetch_pkg::fetch_rsp_t mem_rsp,
  output fetch_pkg::fetch_req_t mem_req,
  input  logic                  buffer_out_stall,
  output fetch_pkg::buffer_in_t buffer_in
);

  typedef enum logic {
    FETCH_IDLE,
    FETCH_RUN
  } fetch_state_e;

  fetch_state_e state;
  fetch_state_e state_next;
  logic [31:0]  fetch_addr;
  logic [31:0]  fetch_addr_next;
  logic [31:0]  flight_pc;
  logic [31:0]  flight_pc_next;

  always_comb begin
    state_next      = state;
    fetch_addr_next = fetch_addr;
    flight_pc_next  = flight_pc;
    mem_req.valid   = 1'b0;
    mem_req.addr    = fetch_addr;

    if (redirect) begin
      // Keep the halfword offset for the first packet only.
      state_next      = FETCH_RUN;
      mem_req.valid   = 1'b1;
      mem_req.addr    = {redirect_pc[31:3], 3'b000};
      flight_pc_next  = {redirect_pc[31:1], 1'b0};
      fetch_addr_next = {redirect_pc[31:3], 3'b000} + 32'd8;
    end else if (state == FETCH_RUN && !buffer_out_stall) begin
      mem_req.valid   = 1'b1;
      flight_pc_next  = fetch_addr;
      fetch_addr_next = fetch_addr + 32'd8;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state      <= FETCH_IDLE;
      fetch_addr <= '0;
      flight_pc  <= '0;
    end else begin
      state      <= state_next;
      fetch_addr <= fetch_addr_next;
      flight_pc  <= flight_pc_next;
    end
  end

  assign buffer_in.pc    = flight_pc;
  assign buffer_in.rdata = mem_rsp.rdata;
  assign buffer_in.ready = mem_rsp.ready;
  assign buffer_in.clear = redirect;
  assign buffer_in.stall = backend_stall;

  assert property (@(posedge clock) disable iff (!reset)
    mem_req.valid |-> mem_req.addr[2:0] == 3'b000);

endmodule

`default_nettype wire

//--- hdl/buffer.sv
`default_nettype none
`timescale 1ns/1ps

module buffer (
  input  logic                   clock,
  input  logic                   reset,
  input  fetch_pkg::buffer_in_t  buffer_in,
  output fetch_pkg::buffer_out_t buffer_out
);

  import buffer_pkg::*;

  buffer_wr_t buffer_wr;
  buffer_rd_t buffer_rd;

  buffer_ctrl u_buffer_ctrl (
    .clock      (clock),
    .reset      (reset),
    .buffer_in  (buffer_in),
    .buffer_out (buffer_out),
    .buffer_rd  (buffer_rd),
    .buffer_wr  (buffer_wr)
  );

  buffer_reg u_buffer_reg (
    .clock     (clock),
    .buffer_wr (buffer_wr),
    .buffer_rd (buffer_rd)
  );

endmodule

`default_nettype wire

//--- hdl/buffer_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_cfg.svh"

module buffer_ctrl (
  input  logic                   clock,
  input  logic                   reset,
  input  fetch_pkg::buffer_in_t  buffer_in,
  output fetch_pkg::buffer_out_t buffer_out,
  input  buffer_pkg::buffer_rd_t buffer_rd,
  output buffer_pkg::buffer_wr_t buffer_wr
);

  import fetch_pkg::*;
  import buffer_pkg::*;

  localparam int PTR_W = ADDR_W + 2;
  localparam int CNT_W = ADDR_W + 3;
  localparam logic [CNT_W-1:0] STALL_LEVEL = CNT_W'(`FETCH_HALFWORDS * `BUFFER_DEPTH - 4);
  localparam logic [CNT_W-1:0] MAX_COUNT = CNT_W'(`FETCH_HALFWORDS * `BUFFER_DEPTH);

  entry_addr_t      wid;
  entry_addr_t      wid_next;
  logic [PTR_W-1:0] rid;
  logic [PTR_W-1:0] rid_cur;
  logic [PTR_W-1:0] rid_next;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_cur;
  logic [CNT_W-1:0] count_now;
  logic [CNT_W-1:0] count_next;
  logic             clear;
  logic             clear_next;
  logic             stall;
  logic             stall_next;

  logic             wen;
  logic             first;
  logic             go;
  logic [1:0]       skip;
  logic [1:0]       align;
  logic [2:0]       incr;

  entry_t [`FETCH_HALFWORDS-1:0] lane_data;
  entry_t [`FETCH_HALFWORDS-1:0] slot;

  instr_len_e       len0;
  instr_len_e       len1;
  logic [2:0]       used0;
  logic [2:0]       need1;
  logic [1:0]       idx1;
  logic [2:0]       consumed;
  logic             ready0;
  logic             ready1;
  logic [31:0]      instr0;
  logic [31:0]      instr1;

  // Pointers, write port and realignment.
  always_comb begin
    wen   = buffer_in.ready & ~buffer_in.clear & ~stall;
    first = wen & clear;
    skip  = first ? buffer_in.pc[2:1] : 2'd0;
    incr  = wen ? (3'd4 - {1'b0, skip}) : 3'd0;

    // First packet after a redirect starts at the target halfword.
    if (buffer_in.clear) begin
      rid_cur   = '0;
      count_cur = '0;
    end else if (first) begin
      rid_cur   = {rid[PTR_W-1:2], buffer_in.pc[2:1]};
      count_cur = count;
    end else begin
      rid_cur   = rid;
      count_cur = count;
    end

    align     = rid_cur[1:0];
    count_now = count_cur + CNT_W'(incr);

    for (int l = 0; l < `FETCH_HALFWORDS; l++) begin
      buffer_wr.wen[l]        = wen;
      buffer_wr.waddr[l]      = wid;
      buffer_wr.wdata[l].pc   = {buffer_in.pc[31:3], 2'(l), 1'b0};
      buffer_wr.wdata[l].data = buffer_in.rdata[16*l +: 16];
      // Lanes below the offset belong to the next entry.
      buffer_wr.raddr[l]      = rid_cur[PTR_W-1:2] + entry_addr_t'(l < int'(align));
      if (wen && buffer_wr.raddr[l] == wid) begin
        lane_data[l] = buffer_wr.wdata[l];
      end else begin
        lane_data[l] = buffer_rd.rdata[l];
      end
    end

    for (int s = 0; s < `FETCH_HALFWORDS; s++) begin
      slot[s] = lane_data[2'(s + int'(align))];
    end
  end

  // Two slot extraction.
  always_comb begin
    go     = ~buffer_in.stall;
    ready0 = 1'b0;
    ready1 = 1'b0;
    instr0 = '0;
    instr1 = '0;

    len0  = instr_len(slot[0].data);
    used0 = (len0 == LEN_32) ? 3'd2 : 3'd1;
    if (go && count_now >= CNT_W'(used0)) begin
      ready0 = 1'b1;
      if (len0 == LEN_32) begin
        instr0 = {slot[1].data, slot[0].data};
      end else begin
        instr0 = {16'h0000, slot[0].data};
      end
    end

    // Second instruction starts right after the first.
    idx1  = used0[1:0];
    len1  = instr_len(slot[idx1].data);
    need1 = used0 + ((len1 == LEN_32) ? 3'd2 : 3'd1);
    if (ready0 && count_now >= CNT_W'(need1)) begin
      ready1 = 1'b1;
      if (len1 == LEN_32) begin
        instr1 = {slot[idx1 + 2'd1].data, slot[idx1].data};
      end else begin
        instr1 = {16'h0000, slot[idx1].data};
      end
    end

    if (ready1) begin
      consumed = need1;
    end else if (ready0) begin
      consumed = used0;
    end else begin
      consumed = 3'd0;
    end

    count_next = count_now - CNT_W'(consumed);
    rid_next   = rid_cur + PTR_W'(consumed);
    wid_next   = buffer_in.clear ? '0 : wid + entry_addr_t'(wen);
    clear_next = buffer_in.clear | (clear & ~first);
    stall_next = count_next > STALL_LEVEL;
  end

  assign buffer_out.pc0    = ready0 ? slot[0].pc : '1;
  assign buffer_out.pc1    = ready1 ? slot[idx1].pc : '1;
  assign buffer_out.instr0 = instr0;
  assign buffer_out.instr1 = instr1;
  assign buffer_out.ready0 = ready0;
  assign buffer_out.ready1 = ready1;
  assign buffer_out.stall  = stall_next;

  always_ff @(posedge clock) begin
    if (!reset) begin
      wid   <= '0;
      rid   <= '0;
      count <= '0;
      clear <= 1'b0;
      stall <= 1'b0;
    end else begin
      wid   <= wid_next;
      rid   <= rid_next;
      count <= count_next;
      clear <= clear_next;
      stall <= stall_next;
    end
  end

  // Occupancy bounded by storage.
  assert property (@(posedge clock) disable iff (!reset) count <= MAX_COUNT);

  // Second slot follows the first in the stored stream.
  assert property (@(posedge clock) disable iff (!reset)
    buffer_out.ready1 |-> buffer_out.ready0 &&
      buffer_out.pc1 == buffer_out.pc0 +
        ((instr_len(buffer_out.instr0[15:0]) == LEN_32) ? 32'd4 : 32'd2));

endmodule

`default_nettype wire

//--- hdl/buffer_reg.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_cfg.svh"

module buffer_reg (
  input  logic                   clock,
  input  buffer_pkg::buffer_wr_t buffer_wr,
  output buffer_pkg::buffer_rd_t buffer_rd
);

  import buffer_pkg::*;

  // Each lane has its own address, so a read may span two entries.
  for (genvar l = 0; l < `FETCH_HALFWORDS; l++) begin : g_lane
    entry_t lane_mem [`BUFFER_DEPTH];

    always_ff @(posedge clock) begin
      if (buffer_wr.wen[l]) begin
        lane_mem[buffer_wr.waddr[l]] <= buffer_wr.wdata[l];
      end
    end

    assign buffer_rd.rdata[l] = lane_mem[buffer_wr.raddr[l]];
  end

endmodule

`default_nettype wire

//--- hdl/buffer_pkg.sv
`default_nettype none

`include "fetch_cfg.svh"

package buffer_pkg;

  localparam int ADDR_W = $clog2(`BUFFER_DEPTH);

  typedef logic [ADDR_W-1:0] entry_addr_t;

  // One stored halfword with the PC it was fetched from.
  typedef struct packed {
    logic [31:0] pc;
    logic [15:0] data;
  } entry_t;

  typedef struct packed {
    logic        [`FETCH_HALFWORDS-1:0] wen;
    entry_addr_t [`FETCH_HALFWORDS-1:0] waddr;
    entry_addr_t [`FETCH_HALFWORDS-1:0] raddr;
    entry_t      [`FETCH_HALFWORDS-1:0] wdata;
  } buffer_wr_t;

  typedef struct packed {
    entry_t [`FETCH_HALFWORDS-1:0] rdata;
  } buffer_rd_t;

endpackage

`default_nettype wire

//--- hdl/fetch_pkg.sv
`default_nettype none

`include "fetch_cfg.svh"

package fetch_pkg;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic                            ready;
    logic [`FETCH_HALFWORDS*16-1:0] rdata;
  } fetch_rsp_t;

  typedef struct packed {
    logic [31:0]                     pc;
    logic [`FETCH_HALFWORDS*16-1:0] rdata;
    logic                            ready;
    logic                            clear;
    logic                            stall;
  } buffer_in_t;

  typedef struct packed {
    logic [31:0] pc0;
    logic [31:0] pc1;
    logic [31:0] instr0;
    logic [31:0] instr1;
    logic        ready0;
    logic        ready1;
    logic        stall;
  } buffer_out_t;

  // Back end view of the buffer output.
  typedef struct packed {
    logic [31:0] pc0;
    logic [31:0] pc1;
    logic [31:0] instr0;
    logic [31:0] instr1;
    logic        ready0;
    logic        ready1;
  } issue_t;

  typedef enum logic {
    LEN_16,
    LEN_32
  } instr_len_e;

  // Full length instructions have both low bits set.
  function automatic instr_len_e instr_len(input logic [15:0] halfword);
    return (halfword[1:0] == 2'b11) ? LEN_32 : LEN_16;
  endfunction

endpackage

`default_nettype wire

//--- include/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Storage entries, one fetch packet each. Power of two, at least 4.
`define BUFFER_DEPTH 8

// Halfwords in one fetch packet.
`define FETCH_HALFWORDS 4

`endif
